// File: files.f
+incdir+test
rtl/decode_pkg.sv
rtl/inst_decoder.sv
rtl/operand_fwd.sv
rtl/branch_issue.sv
rtl/id_stage.sv
test/tb_id_stage.sv

// File: rtl/branch_issue.sv
`timescale 1ns/1ps

module branch_issue (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        valid_i,
    input  logic                        stall_i,
    input  logic [decode_pkg::XLEN-1:0] pc_i,
    input  logic [decode_pkg::XLEN-1:0] inst_i,
    input  decode_pkg::dec_ctrl_t       ctrl_i,
    input  logic [decode_pkg::XLEN-1:0] op1_i,
    input  logic [decode_pkg::XLEN-1:0] op2_i,
    output logic                        valid_o,
    output decode_pkg::id_out_t         out_o
);
    import decode_pkg::*;

    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] pc_plus8;
    logic [XLEN-1:0] br_off;
    logic [XLEN-1:0] target;
    logic            taken;
    logic            link;
    id_out_t         next_out;

    assign pc_plus4 = pc_i + 32'd4;
    assign pc_plus8 = pc_i + 32'd8;   // past the delay slot
    assign br_off   = {{14{inst_i[15]}}, inst_i[15:0], 2'b00};

    always_comb begin
        taken  = 1'b0;
        target = pc_plus4 + br_off;
        case (ctrl_i.aluop)
            ALU_J, ALU_JAL: begin
                taken  = 1'b1;
                target = {pc_plus4[31:28], inst_i[25:0], 2'b00};
            end
            ALU_JR, ALU_JALR: begin
                taken  = 1'b1;
                target = op1_i;
            end
            ALU_BEQ:                taken = (op1_i == op2_i);
            ALU_BNE:                taken = (op1_i != op2_i);
            ALU_BGTZ:               taken = !op1_i[31] && (op1_i != '0);
            ALU_BLEZ:               taken = op1_i[31] || (op1_i == '0);
            ALU_BGEZ, ALU_BGEZAL:   taken = !op1_i[31];
            ALU_BLTZ, ALU_BLTZAL:   taken = op1_i[31];
            default:                taken = 1'b0;
        endcase
        link = ctrl_i.aluop inside {ALU_JAL, ALU_JALR, ALU_BGEZAL, ALU_BLTZAL};
    end

    always_comb begin
        next_out               = '0;
        next_out.ctrl          = ctrl_i;
        next_out.ctrl.wreg     = ctrl_i.wreg && valid_i;  // bubble writes nothing
        next_out.op1           = op1_i;
        next_out.op2           = op2_i;
        next_out.branch_flag   = taken && valid_i;
        next_out.branch_target = taken ? target : '0;
        next_out.link_addr     = link ? pc_plus8 : '0;
        next_out.pc            = pc_i;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o <= 1'b0;
            out_o   <= '0;
        end else if (!stall_i) begin
            valid_o <= valid_i;
            out_o   <= next_out;
        end
    end

    a_reset_clears_valid: assert property (@(posedge clk_i) reset_i |=> !valid_o)
        else $error("valid_o high after reset edge");

endmodule

// File: rtl/decode_pkg.sv
package decode_pkg;

    localparam int XLEN    = 32;
    localparam int REG_AW  = 5;
    localparam int NUM_SRC = 2;

    localparam logic [REG_AW-1:0] LINK_REG = 5'd31; // $ra

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_REGIMM  = 6'b000001;
    localparam logic [5:0] OP_J       = 6'b000010;
    localparam logic [5:0] OP_JAL     = 6'b000011;
    localparam logic [5:0] OP_BEQ     = 6'b000100;
    localparam logic [5:0] OP_BNE     = 6'b000101;
    localparam logic [5:0] OP_BLEZ    = 6'b000110;
    localparam logic [5:0] OP_BGTZ    = 6'b000111;
    localparam logic [5:0] OP_ADDI    = 6'b001000;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_SLTI    = 6'b001010;
    localparam logic [5:0] OP_SLTIU   = 6'b001011;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;

    // SPECIAL funct field
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_SLLV = 6'b000100;
    localparam logic [5:0] FN_SRLV = 6'b000110;
    localparam logic [5:0] FN_SRAV = 6'b000111;
    localparam logic [5:0] FN_JR   = 6'b001000;
    localparam logic [5:0] FN_JALR = 6'b001001;
    localparam logic [5:0] FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;

    // REGIMM rt field
    localparam logic [4:0] RT_BLTZ   = 5'b00000;
    localparam logic [4:0] RT_BGEZ   = 5'b00001;
    localparam logic [4:0] RT_BLTZAL = 5'b10000;
    localparam logic [4:0] RT_BGEZAL = 5'b10001;

    typedef enum logic [4:0] {
        ALU_NOP, ALU_OR, ALU_AND, ALU_XOR, ALU_NOR,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_ADD, ALU_ADDU, ALU_ADDI, ALU_ADDIU,
        ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU,
        ALU_J, ALU_JAL, ALU_JR, ALU_JALR,
        ALU_BEQ, ALU_BNE, ALU_BGTZ, ALU_BLEZ,
        ALU_BGEZ, ALU_BLTZ, ALU_BGEZAL, ALU_BLTZAL
    } aluop_e;

    typedef enum logic [2:0] {
        SEL_NOP,
        SEL_LOGIC,
        SEL_SHIFT,
        SEL_ARITH,
        SEL_JUMP_BRANCH
    } alusel_e;

    typedef struct packed {
        aluop_e            aluop;
        alusel_e           alusel;
        logic [REG_AW-1:0] wd;           // destination register
        logic              wreg;
        logic              inst_invalid;
    } dec_ctrl_t;

    typedef struct packed {
        logic              re;
        logic [REG_AW-1:0] addr;
    } rd_req_t;

    // late result from EX or MEM
    typedef struct packed {
        logic              we;
        logic [REG_AW-1:0] wd;
        logic [XLEN-1:0]   data;
    } bypass_t;

    typedef struct packed {
        dec_ctrl_t       ctrl;
        logic [XLEN-1:0] op1;
        logic [XLEN-1:0] op2;
        logic            branch_flag;
        logic [XLEN-1:0] branch_target;
        logic [XLEN-1:0] link_addr;
        logic [XLEN-1:0] pc;
    } id_out_t;

endpackage

// File: rtl/id_stage.sv
`timescale 1ns/1ps

module id_stage (
    input  logic                                          clk_i,
    input  logic                                          reset_i,
    input  logic                                          valid_i,
    input  logic                                          stall_i,
    input  logic [decode_pkg::XLEN-1:0]                   pc_i,
    input  logic [decode_pkg::XLEN-1:0]                   inst_i,
    input  logic [decode_pkg::NUM_SRC-1:0][decode_pkg::XLEN-1:0] rf_data_i,
    input  decode_pkg::bypass_t                           ex_byp_i,
    input  decode_pkg::bypass_t                           mem_byp_i,
    output decode_pkg::rd_req_t [decode_pkg::NUM_SRC-1:0] rd_req_o,
    output logic                                          valid_o,
    output decode_pkg::id_out_t                           id_o
);
    import decode_pkg::*;

    dec_ctrl_t                     ctrl;
    logic [XLEN-1:0]               imm;
    logic [NUM_SRC-1:0][XLEN-1:0]  src_op;

    inst_decoder u_dec (
        .inst_i   (inst_i),
        .pc_i     (pc_i),
        .ctrl_o   (ctrl),
        .rd_req_o (rd_req_o),
        .imm_o    (imm)
    );

    // one slice per source operand, rs then rt
    for (genvar i = 0; i < NUM_SRC; i++) begin : g_fwd
        operand_fwd u_fwd (
            .req_i     (rd_req_o[i]),
            .rf_data_i (rf_data_i[i]),
            .ex_byp_i  (ex_byp_i),
            .mem_byp_i (mem_byp_i),
            .imm_i     (imm),
            .op_o      (src_op[i])
        );
    end

    branch_issue u_issue (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .valid_i (valid_i),
        .stall_i (stall_i),
        .pc_i    (pc_i),
        .inst_i  (inst_i),
        .ctrl_i  (ctrl),
        .op1_i   (src_op[0]),
        .op2_i   (src_op[1]),
        .valid_o (valid_o),
        .out_o   (id_o)
    );

endmodule

// File: rtl/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  logic [decode_pkg::XLEN-1:0]                   inst_i,
    input  logic [decode_pkg::XLEN-1:0]                   pc_i,
    output decode_pkg::dec_ctrl_t                         ctrl_o,
    output decode_pkg::rd_req_t [decode_pkg::NUM_SRC-1:0] rd_req_o,
    output logic [decode_pkg::XLEN-1:0]                   imm_o
);
    import decode_pkg::*;

    logic [5:0]        op;
    logic [REG_AW-1:0] rs;
    logic [REG_AW-1:0] rt;
    logic [REG_AW-1:0] rd;
    logic [4:0]        shamt;
    logic [5:0]        funct;
    logic              sa_form; // sll/srl/sra funct group
    logic              i_form;  // addi .. lui

    aluop_e            aluop;
    alusel_e           alusel;
    logic [REG_AW-1:0] wd;
    logic              wreg;
    logic              invalid;
    logic              rs_re;
    logic              rt_re;
    logic [XLEN-1:0]   imm;

    assign op    = inst_i[31:26];
    assign rs    = inst_i[25:21];
    assign rt    = inst_i[20:16];
    assign rd    = inst_i[15:11];
    assign shamt = inst_i[10:6];
    assign funct = inst_i[5:0];

    assign sa_form = (funct[5:2] == 4'b0000);
    assign i_form  = (op[5:3] == 3'b001);

    always_comb begin
        aluop   = ALU_NOP;
        wd      = rd;
        wreg    = 1'b0;
        invalid = 1'b1;
        rs_re   = 1'b0;
        rt_re   = 1'b0;
        imm     = '0;

        case (op)
            OP_SPECIAL: begin
                case (funct)
                    FN_OR:   aluop = ALU_OR;
                    FN_AND:  aluop = ALU_AND;
                    FN_XOR:  aluop = ALU_XOR;
                    FN_NOR:  aluop = ALU_NOR;
                    FN_SLLV: aluop = ALU_SLL;
                    FN_SRLV: aluop = ALU_SRL;
                    FN_SRAV: aluop = ALU_SRA;
                    FN_ADD:  aluop = ALU_ADD;
                    FN_ADDU: aluop = ALU_ADDU;
                    FN_SUB:  aluop = ALU_SUB;
                    FN_SUBU: aluop = ALU_SUBU;
                    FN_SLT:  aluop = ALU_SLT;
                    FN_SLTU: aluop = ALU_SLTU;
                    FN_JR:   aluop = ALU_JR;
                    FN_JALR: aluop = ALU_JALR;
                    // fixed shifts need rs field zero
                    FN_SLL:  aluop = (rs == '0) ? ALU_SLL : ALU_NOP;
                    FN_SRL:  aluop = (rs == '0) ? ALU_SRL : ALU_NOP;
                    FN_SRA:  aluop = (rs == '0) ? ALU_SRA : ALU_NOP;
                    default: aluop = ALU_NOP;
                endcase
                if (aluop != ALU_NOP) begin
                    invalid = 1'b0;
                    wreg    = (aluop != ALU_JR);
                    rs_re   = !sa_form;
                    rt_re   = !(aluop inside {ALU_JR, ALU_JALR});
                    if (sa_form) begin
                        imm[4:0] = shamt; // shift amount goes in as op1
                    end
                end
            end
            OP_ORI:   aluop = ALU_OR;
            OP_ANDI:  aluop = ALU_AND;
            OP_XORI:  aluop = ALU_XOR;
            OP_LUI:   aluop = ALU_OR;
            OP_ADDI:  aluop = ALU_ADDI;
            OP_ADDIU: aluop = ALU_ADDIU;
            OP_SLTI:  aluop = ALU_SLT;
            OP_SLTIU: aluop = ALU_SLTU;
            OP_J: begin
                aluop   = ALU_J;
                invalid = 1'b0;
            end
            OP_JAL: begin
                aluop   = ALU_JAL;
                wreg    = 1'b1;
                wd      = LINK_REG;
                invalid = 1'b0;
            end
            OP_BEQ, OP_BNE: begin
                aluop   = (op == OP_BEQ) ? ALU_BEQ : ALU_BNE;
                rs_re   = 1'b1;
                rt_re   = 1'b1;
                invalid = 1'b0;
            end
            OP_BGTZ, OP_BLEZ: begin
                aluop   = (op == OP_BGTZ) ? ALU_BGTZ : ALU_BLEZ;
                rs_re   = 1'b1;
                invalid = 1'b0;
            end
            OP_REGIMM: begin
                case (rt)
                    RT_BGEZ:   aluop = ALU_BGEZ;
                    RT_BLTZ:   aluop = ALU_BLTZ;
                    RT_BGEZAL: aluop = ALU_BGEZAL;
                    RT_BLTZAL: aluop = ALU_BLTZAL;
                    default:   aluop = ALU_NOP;
                endcase
                if (aluop != ALU_NOP) begin
                    rs_re   = 1'b1;
                    invalid = 1'b0;
                    if (rt[4]) begin // linking forms
                        wreg = 1'b1;
                        wd   = LINK_REG;
                    end
                end
            end
            default: aluop = ALU_NOP;
        endcase

        if (i_form) begin
            rs_re   = 1'b1;
            wd      = rt;
            wreg    = 1'b1;
            invalid = 1'b0;
            if (op == OP_LUI) begin
                imm = {inst_i[15:0], 16'h0};
            end else if (op[2]) begin
                imm = {16'h0, inst_i[15:0]}; // andi/ori/xori
            end else begin
                imm = {{16{inst_i[15]}}, inst_i[15:0]};
            end
        end
    end

    always_comb begin
        case (aluop)
            ALU_NOP:                           alusel = SEL_NOP;
            ALU_OR, ALU_AND, ALU_XOR, ALU_NOR: alusel = SEL_LOGIC;
            ALU_SLL, ALU_SRL, ALU_SRA:         alusel = SEL_SHIFT;
            ALU_ADD, ALU_ADDU, ALU_ADDI, ALU_ADDIU,
            ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU: alusel = SEL_ARITH;
            default:                           alusel = SEL_JUMP_BRANCH;
        endcase
    end

    assign ctrl_o = '{aluop: aluop, alusel: alusel, wd: wd, wreg: wreg, inst_invalid: invalid};

    assign rd_req_o[0] = '{re: rs_re, addr: rs};
    assign rd_req_o[1] = '{re: rt_re, addr: rt};
    assign imm_o       = imm;

    // an undecoded word must not touch the register file
    a_no_read_on_invalid: assert final ($isunknown(inst_i) || !ctrl_o.inst_invalid ||
                                        !(rd_req_o[0].re || rd_req_o[1].re))
        else $error("read request for invalid instruction %h at pc %h", inst_i, pc_i);

endmodule

// File: rtl/operand_fwd.sv
`timescale 1ns/1ps

module operand_fwd (
    input  decode_pkg::rd_req_t         req_i,
    input  logic [decode_pkg::XLEN-1:0] rf_data_i,
    input  decode_pkg::bypass_t         ex_byp_i,
    input  decode_pkg::bypass_t         mem_byp_i,
    input  logic [decode_pkg::XLEN-1:0] imm_i,
    output logic [decode_pkg::XLEN-1:0] op_o
);

    logic ex_hit;
    logic mem_hit;

    // register 0 gets no special treatment here
    assign ex_hit  = req_i.re && ex_byp_i.we && (ex_byp_i.wd == req_i.addr);
    assign mem_hit = req_i.re && mem_byp_i.we && (mem_byp_i.wd == req_i.addr);

    always_comb begin
        if (ex_hit) begin
            op_o = ex_byp_i.data;  // youngest result wins
        end else if (mem_hit) begin
            op_o = mem_byp_i.data;
        end else if (req_i.re) begin
            op_o = rf_data_i;
        end else begin
            op_o = imm_i;          // no read, immediate operand
        end
    end

    a_ex_over_mem: assert final (!(ex_hit && mem_hit) || op_o == ex_byp_i.data)
        else $error("EX bypass lost to MEM for r%0d", req_i.addr);

endmodule

// File: test/id_ref.svh
`ifndef ID_REF_SVH
`define ID_REF_SVH

task automatic report_mismatch(input string sig, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
    $display("** Error at %0t: %s is %h, expected %h", $time, sig, got, exp);
    $display("Errors found");
    $fatal(1, "mismatch on %s", sig);
endtask

task automatic report_failure(input string what);
    $display("%s", what);
    $display("Errors found");
    $fatal(1, "%s", what);
endtask

task automatic check_bit(input string sig, input logic got, input logic exp);
    if (got !== exp) report_mismatch(sig, {31'b0, got}, {31'b0, exp});
endtask

task automatic check_word(input string sig, input logic [XLEN-1:0] got,
                          input logic [XLEN-1:0] exp);
    if (got !== exp) report_mismatch(sig, got, exp);
endtask

task automatic check_ctrl(input string sig, input dec_ctrl_t got, input dec_ctrl_t exp);
    if (got !== exp) report_mismatch(sig, XLEN'(got), XLEN'(exp));
endtask

task automatic check_req(input string sig, input rd_req_t got, input rd_req_t exp);
    if (got !== exp) report_mismatch(sig, XLEN'(got), XLEN'(exp));
endtask

task automatic check_out(input id_out_t got, input id_out_t exp);
    check_ctrl("id_o.ctrl", got.ctrl, exp.ctrl);
    check_word("id_o.op1", got.op1, exp.op1);
    check_word("id_o.op2", got.op2, exp.op2);
    check_bit("id_o.branch_flag", got.branch_flag, exp.branch_flag);
    check_word("id_o.branch_target", got.branch_target, exp.branch_target);
    check_word("id_o.link_addr", got.link_addr, exp.link_addr);
    check_word("id_o.pc", got.pc, exp.pc);
endtask

// ex first, then mem, then the register model
function automatic logic [XLEN-1:0] pick_operand(input logic re, input logic [REG_AW-1:0] r,
                                                 input bypass_t ex, input bypass_t mem,
                                                 input logic [XLEN-1:0] imm);
    if (!re) return imm;
    if (ex.we && ex.wd == r) return ex.data;
    if (mem.we && mem.wd == r) return mem.data;
    return regs[r];
endfunction

function automatic id_out_t id_ref(input logic [XLEN-1:0] inst, input logic [XLEN-1:0] pc,
                                   input logic vld, input bypass_t ex, input bypass_t mem,
                                   output rd_req_t [NUM_SRC-1:0] req);
    id_out_t           r;
    aluop_e            op_c;
    logic [5:0]        opc;
    logic [5:0]        fn;
    logic [REG_AW-1:0] rs;
    logic [REG_AW-1:0] rt;
    logic              rs_re;
    logic              rt_re;
    logic              taken;
    logic [XLEN-1:0]   imm;
    logic [XLEN-1:0]   a;
    logic [XLEN-1:0]   b;
    logic [XLEN-1:0]   pc4;
    logic [XLEN-1:0]   tgt;

    r     = '0;
    opc   = inst[31:26];
    fn    = inst[5:0];
    rs    = inst[25:21];
    rt    = inst[20:16];
    op_c  = ALU_NOP;
    rs_re = 1'b0;
    rt_re = 1'b0;
    imm   = '0;
    r.ctrl.wd = inst[15:11];

    case (opc)
        OP_SPECIAL: begin
            case (fn)
                FN_OR:   op_c = ALU_OR;
                FN_AND:  op_c = ALU_AND;
                FN_XOR:  op_c = ALU_XOR;
                FN_NOR:  op_c = ALU_NOR;
                FN_SLLV: op_c = ALU_SLL;
                FN_SRLV: op_c = ALU_SRL;
                FN_SRAV: op_c = ALU_SRA;
                FN_ADD:  op_c = ALU_ADD;
                FN_ADDU: op_c = ALU_ADDU;
                FN_SUB:  op_c = ALU_SUB;
                FN_SUBU: op_c = ALU_SUBU;
                FN_SLT:  op_c = ALU_SLT;
                FN_SLTU: op_c = ALU_SLTU;
                FN_JR:   op_c = ALU_JR;
                FN_JALR: op_c = ALU_JALR;
                FN_SLL:  if (rs == 0) op_c = ALU_SLL;
                FN_SRL:  if (rs == 0) op_c = ALU_SRL;
                FN_SRA:  if (rs == 0) op_c = ALU_SRA;
                default: op_c = ALU_NOP;
            endcase
            if (op_c != ALU_NOP) begin
                rs_re = !(fn inside {FN_SLL, FN_SRL, FN_SRA});
                rt_re = !(fn inside {FN_JR, FN_JALR});
                r.ctrl.wreg = (fn != FN_JR);
                if (!rs_re) imm = {27'b0, inst[10:6]}; // shamt
            end
        end
        OP_ORI, OP_ANDI, OP_XORI, OP_LUI, OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
            rs_re = 1'b1;
            r.ctrl.wd   = rt;
            r.ctrl.wreg = 1'b1;
            imm = {{16{inst[15]}}, inst[15:0]};
            case (opc)
                OP_ORI:   op_c = ALU_OR;
                OP_ANDI:  op_c = ALU_AND;
                OP_XORI:  op_c = ALU_XOR;
                OP_LUI:   op_c = ALU_OR;
                OP_ADDI:  op_c = ALU_ADDI;
                OP_ADDIU: op_c = ALU_ADDIU;
                OP_SLTI:  op_c = ALU_SLT;
                default:  op_c = ALU_SLTU;
            endcase
            if (opc inside {OP_ORI, OP_ANDI, OP_XORI}) imm = {16'h0, inst[15:0]};
            if (opc == OP_LUI) imm = {inst[15:0], 16'h0};
        end
        OP_J:   op_c = ALU_J;
        OP_JAL: begin
            op_c = ALU_JAL;
            r.ctrl.wreg = 1'b1;
            r.ctrl.wd   = LINK_REG;
        end
        OP_BEQ, OP_BNE: begin
            op_c  = (opc == OP_BEQ) ? ALU_BEQ : ALU_BNE;
            rs_re = 1'b1;
            rt_re = 1'b1;
        end
        OP_BGTZ, OP_BLEZ: begin
            op_c  = (opc == OP_BGTZ) ? ALU_BGTZ : ALU_BLEZ;
            rs_re = 1'b1;
        end
        OP_REGIMM: begin
            case (rt)
                RT_BGEZ:   op_c = ALU_BGEZ;
                RT_BLTZ:   op_c = ALU_BLTZ;
                RT_BGEZAL: op_c = ALU_BGEZAL;
                RT_BLTZAL: op_c = ALU_BLTZAL;
                default:   op_c = ALU_NOP;
            endcase
            rs_re = (op_c != ALU_NOP);
            if (op_c inside {ALU_BGEZAL, ALU_BLTZAL}) begin
                r.ctrl.wreg = 1'b1;
                r.ctrl.wd   = LINK_REG;
            end
        end
        default: op_c = ALU_NOP;
    endcase

    r.ctrl.aluop        = op_c;
    r.ctrl.inst_invalid = (op_c == ALU_NOP);
    case (op_c)
        ALU_NOP:                           r.ctrl.alusel = SEL_NOP;
        ALU_OR, ALU_AND, ALU_XOR, ALU_NOR: r.ctrl.alusel = SEL_LOGIC;
        ALU_SLL, ALU_SRL, ALU_SRA:         r.ctrl.alusel = SEL_SHIFT;
        ALU_ADD, ALU_ADDU, ALU_ADDI, ALU_ADDIU,
        ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU: r.ctrl.alusel = SEL_ARITH;
        default:                           r.ctrl.alusel = SEL_JUMP_BRANCH;
    endcase

    // register-file reads, rs then rt
    req[0].re   = rs_re;
    req[0].addr = rs;
    req[1].re   = rt_re;
    req[1].addr = rt;

    a   = pick_operand(rs_re, rs, ex, mem, imm);
    b   = pick_operand(rt_re, rt, ex, mem, imm);
    pc4 = pc + 4;
    tgt = pc4 + {{14{inst[15]}}, inst[15:0], 2'b00};
    case (op_c)
        ALU_J, ALU_JAL: begin
            taken = 1'b1;
            tgt   = {pc4[31:28], inst[25:0], 2'b00};
        end
        ALU_JR, ALU_JALR: begin
            taken = 1'b1;
            tgt   = a;
        end
        ALU_BEQ:              taken = (a == b);
        ALU_BNE:              taken = (a != b);
        ALU_BGTZ:             taken = ($signed(a) > 0);
        ALU_BLEZ:             taken = ($signed(a) <= 0);
        ALU_BGEZ, ALU_BGEZAL: taken = ($signed(a) >= 0);
        ALU_BLTZ, ALU_BLTZAL: taken = ($signed(a) < 0);
        default:              taken = 1'b0;
    endcase

    r.ctrl.wreg      = r.ctrl.wreg && vld;
    r.op1            = a;
    r.op2            = b;
    r.branch_flag    = taken && vld;
    r.branch_target  = taken ? tgt : '0;
    r.link_addr      = (op_c inside {ALU_JAL, ALU_JALR, ALU_BGEZAL, ALU_BLTZAL}) ? pc + 8 : '0;
    r.pc             = pc;
    return r;
endfunction

`endif

// File: test/tb_id_stage.sv
`timescale 1ns/1ps

module tb_id_stage;
    import decode_pkg::*;

    localparam int N_INST = 600;

    logic                         clk_i;
    logic                         reset_i;
    logic                         valid_i;
    logic                         stall_i;
    logic [XLEN-1:0]              pc_i;
    logic [XLEN-1:0]              inst_i;
    logic [NUM_SRC-1:0][XLEN-1:0] rf_data_i;
    bypass_t                      ex_byp_i;
    bypass_t                      mem_byp_i;
    rd_req_t [NUM_SRC-1:0]        rd_req_o;
    logic                         valid_o;
    id_out_t                      id_o;

    logic [XLEN-1:0] regs [32];    // register file model
    id_out_t         exp_q[$];
    logic            exp_valid_q[$];
    id_out_t         cur_exp;
    logic            cur_valid;
    rd_req_t [NUM_SRC-1:0] req_exp; // reads for the word now on inst_i

    `include "id_ref.svh"

    id_stage uut (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .valid_i   (valid_i),
        .stall_i   (stall_i),
        .pc_i      (pc_i),
        .inst_i    (inst_i),
        .rf_data_i (rf_data_i),
        .ex_byp_i  (ex_byp_i),
        .mem_byp_i (mem_byp_i),
        .rd_req_o  (rd_req_o),
        .valid_o   (valid_o),
        .id_o      (id_o)
    );

    assign rf_data_i[0] = regs[rd_req_o[0].addr]; // answers in the same cycle
    assign rf_data_i[1] = regs[rd_req_o[1].addr];

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    function automatic logic [XLEN-1:0] random_inst();
        logic [XLEN-1:0] w;
        int              kind;

        w    = $urandom();
        kind = $urandom_range(0, 9);
        if (kind <= 2) begin
            w[31:26] = OP_SPECIAL;
            case ($urandom_range(0, 3))
                0:       w[5:0] = {3'b100, 3'($urandom_range(0, 7))};  // add .. nor
                1:       w[5:0] = {5'b10101, 1'($urandom_range(0, 1))}; // slt, sltu
                2:       w[5:0] = {3'b000, 3'($urandom_range(0, 7))};  // shifts and holes
                default: w[5:0] = {5'b00100, 1'($urandom_range(0, 1))}; // jr, jalr
            endcase
            if (w[5:2] == 4'b0000 && $urandom_range(0, 7) != 0) w[25:21] = '0;
        end else if (kind <= 4) begin
            w[31:26] = {3'b001, 3'($urandom_range(0, 7))};
        end else if (kind == 5) begin
            w[31:26] = 6'($urandom_range(2, 3));
        end else if (kind <= 7) begin
            w[31:26] = 6'($urandom_range(4, 7));
            if ($urandom_range(0, 3) == 0) w[20:16] = w[25:21]; // beq taken
        end else if (kind == 8) begin
            w[31:26] = OP_REGIMM;
            w[20:16] = {1'($urandom_range(0, 1)), 3'b000, 1'($urandom_range(0, 1))};
        end
        return w;
    endfunction

    // mostly aimed at rs or rt
    function automatic bypass_t random_bypass(input logic [REG_AW-1:0] rs,
                                              input logic [REG_AW-1:0] rt);
        bypass_t b;

        b.we   = ($urandom_range(0, 3) != 0);
        b.data = $urandom();
        case ($urandom_range(0, 2))
            0:       b.wd = rs;
            1:       b.wd = rt;
            default: b.wd = REG_AW'($urandom());
        endcase
        return b;
    endfunction

    initial begin
        int      sent;
        int      stall_left;
        id_out_t exp_now;

        void'($urandom(67));
        reset_i   = 1'b1;
        valid_i   = 1'b0;
        stall_i   = 1'b0;
        pc_i      = '0;
        inst_i    = '0;
        ex_byp_i  = '0;
        mem_byp_i = '0;
        regs[0]   = '0;
        for (int k = 1; k < 32; k++) regs[k] = $urandom();
        sent       = 0;
        stall_left = 0;

        repeat (4) @(posedge clk_i);
        #2;
        reset_i = 1'b0;
        while (sent < N_INST) begin
            if (stall_left == 0 && $urandom_range(0, 9) == 0) stall_left = $urandom_range(1, 6);
            stall_i = (stall_left > 0);
            if (stall_left > 0) stall_left--;
            valid_i   = ($urandom_range(0, 7) != 0);
            inst_i    = random_inst();
            pc_i      = $urandom() & 32'hffff_fffc;
            ex_byp_i  = random_bypass(inst_i[25:21], inst_i[20:16]);
            mem_byp_i = random_bypass(inst_i[25:21], inst_i[20:16]);
            exp_now   = id_ref(inst_i, pc_i, valid_i, ex_byp_i, mem_byp_i, req_exp);
            if (!stall_i) begin
                exp_q.push_back(exp_now);
                exp_valid_q.push_back(valid_i);
                sent++;
            end
            @(posedge clk_i);
            #2;
        end

        stall_i = 1'b1;   // freeze so the last result can be checked
        valid_i = 1'b0;
        @(negedge clk_i);
        #1;
        $display("No errors");
        $finish;
    end

    // compares one cycle after each accepted edge, holds across stalls
    initial begin
        cur_exp   = '0;
        cur_valid = 1'b0;
        forever begin
            @(posedge clk_i);
            if (reset_i) begin
                cur_exp   = '0;
                cur_valid = 1'b0;
            end else if (!stall_i) begin
                if (exp_q.size() == 0) report_failure("stage accepted a cycle with nothing queued");
                cur_exp   = exp_q.pop_front();
                cur_valid = exp_valid_q.pop_front();
            end
            @(negedge clk_i);
            check_bit("valid_o", valid_o, cur_valid);
            check_out(id_o, cur_exp);
            if (!reset_i) begin
                check_req("rd_req_o[0]", rd_req_o[0], req_exp[0]); // same-cycle reads
                check_req("rd_req_o[1]", rd_req_o[1], req_exp[1]);
            end
        end
    end

endmodule
